/* hw/cu_cache_pkg.sv */
/*
  Widths, FIFO sizing, command codes and sequencer states for the cache port
  Request record packs as {cmd, addr, wdata, wstrb, tag}, MSB first
  Response record packs as {cmd, tag, rdata}, MSB first
  STRB_W must stay DATA_W / 8, one strobe per byte lane
  FIFO_PROG_THRESH must stay below FIFO_DEPTH
*/
`default_nettype none

package cu_cache_pkg;

  // --------------------
  // Field widths
  // --------------------
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int TAG_W  = 8;

  // Byte address, word data, byte lanes, request tag
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [TAG_W-1:0]  tag_t;

  // --------------------
  // Command codes
  // --------------------
  typedef logic cmd_t;

  localparam cmd_t CMD_READ  = 1'b0;
  localparam cmd_t CMD_WRITE = 1'b1;

  // --------------------
  // Packed record widths
  // --------------------
  localparam int REQ_BITS = $bits(cmd_t) + ADDR_W + DATA_W + STRB_W + TAG_W;
  localparam int RSP_BITS = $bits(cmd_t) + TAG_W + DATA_W;

  // --------------------
  // FIFO sizing
  // --------------------
  localparam int FIFO_DEPTH       = 16;
  // Entries at which prog_full rises
  localparam int FIFO_PROG_THRESH = 12;

  // Command sequencer states
  typedef enum logic [2:0] {
    seq_reset,
    seq_ready,
    seq_read_trans,
    seq_read,
    seq_write_trans,
    seq_write,
    seq_pop_trans,
    seq_pop
  } seq_state_e;

endpackage

`default_nettype wire

/* hw/sync_fifo.sv */
/*
  Synchronous FIFO, first word fall through
  Head entry is always on dout_o, valid only while empty_o is low
  Writes while full and reads while empty are dropped
  prog_full_o is a level, high while count >= PROG_THRESH
  Storage has no reset, only pointers and count are cleared
*/
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH       = 32,
  parameter int DEPTH       = 16,
  parameter int PROG_THRESH = 12
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic             wr_en_i,
  input  logic [WIDTH-1:0] din_i,
  input  logic             rd_en_i,
  output logic [WIDTH-1:0] dout_o,
  output logic             empty_o,
  output logic             full_o,
  output logic             prog_full_o
);

  // Circular storage
  logic [WIDTH-1:0] mem [DEPTH];

  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  // Occupancy, needs one more state than DEPTH
  logic [$clog2(DEPTH+1)-1:0] count;

  logic do_wr;
  logic do_rd;

  // Accepted operations only
  assign do_wr = wr_en_i & ~full_o;
  assign do_rd = rd_en_i & ~empty_o;

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap explicitly, DEPTH need not be a power of two
      if (do_wr) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage write
  always_ff @(posedge ap_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din_i;
    end
  end

  // Head entry falls through
  assign dout_o = mem[rd_ptr];

  // Status levels
  assign empty_o     = (count == 0);
  assign full_o      = (count == DEPTH);
  assign prog_full_o = (count >= PROG_THRESH);

endmodule

`default_nettype wire

/* hw/cache_cmd_sequencer.sv */
/*
  Command sequencer, one memory command in flight at a time
  Starts only with a head entry, response FIFO below prog_full and mem_ready_i
  mem_valid_o is a one-cycle strobe, strobes are forced to zero for reads
  Reads wait for a single mem_rvalid_i pulse, writes expect no reply
  Request pop and response push are issued together from pop_trans
*/
`timescale 1ns/1ps
`default_nettype none

module cache_cmd_sequencer (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  input  logic                              req_empty_i,
  input  logic [cu_cache_pkg::REQ_BITS-1:0] req_head_i,
  input  logic                              rsp_prog_full_i,
  input  logic                              mem_ready_i,
  input  logic                              mem_rvalid_i,
  input  cu_cache_pkg::data_t               mem_rdata_i,
  output logic                              req_pop_o,
  output logic                              rsp_push_o,
  output logic [cu_cache_pkg::RSP_BITS-1:0] rsp_din_o,
  output logic                              mem_valid_o,
  output cu_cache_pkg::addr_t               mem_addr_o,
  output cu_cache_pkg::data_t               mem_wdata_o,
  output cu_cache_pkg::strb_t               mem_wstrb_o,
  output logic                              busy_o
);

  cu_cache_pkg::seq_state_e state_q;
  cu_cache_pkg::seq_state_e state_d;

  // Fields of the request FIFO head
  cu_cache_pkg::cmd_t  head_cmd;
  cu_cache_pkg::addr_t head_addr;
  cu_cache_pkg::data_t head_wdata;
  cu_cache_pkg::strb_t head_wstrb;
  cu_cache_pkg::tag_t  head_tag;

  // Command copy carried into the response
  cu_cache_pkg::cmd_t  cmd_q;
  cu_cache_pkg::tag_t  tag_q;
  cu_cache_pkg::data_t rdata_q;
  cu_cache_pkg::data_t rsp_rdata;

  logic issue_ok;

  assign {head_cmd, head_addr, head_wdata, head_wstrb, head_tag} = req_head_i;

  // Work waiting, room for its response, memory willing
  assign issue_ok = ~req_empty_i & ~rsp_prog_full_i & mem_ready_i;

  // --------------------
  // State register
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state_q <= cu_cache_pkg::seq_reset;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      cu_cache_pkg::seq_reset: begin
        state_d = cu_cache_pkg::seq_ready;
      end
      cu_cache_pkg::seq_ready: begin
        if (issue_ok && head_cmd == cu_cache_pkg::CMD_READ) begin
          state_d = cu_cache_pkg::seq_read_trans;
        end else if (issue_ok) begin
          state_d = cu_cache_pkg::seq_write_trans;
        end
      end
      // Strobe is registered here, visible in the next state
      cu_cache_pkg::seq_read_trans:  state_d = cu_cache_pkg::seq_read;
      cu_cache_pkg::seq_read: begin
        if (mem_rvalid_i) begin
          state_d = cu_cache_pkg::seq_pop_trans;
        end
      end
      cu_cache_pkg::seq_write_trans: state_d = cu_cache_pkg::seq_write;
      cu_cache_pkg::seq_write:       state_d = cu_cache_pkg::seq_pop_trans;
      cu_cache_pkg::seq_pop_trans:   state_d = cu_cache_pkg::seq_pop;
      cu_cache_pkg::seq_pop:         state_d = cu_cache_pkg::seq_ready;
      default:                       state_d = cu_cache_pkg::seq_reset;
    endcase
  end

  // --------------------
  // Registered strobes
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      mem_valid_o <= 1'b0;
      req_pop_o   <= 1'b0;
      rsp_push_o  <= 1'b0;
    end else begin
      mem_valid_o <= (state_q == cu_cache_pkg::seq_read_trans) ||
                     (state_q == cu_cache_pkg::seq_write_trans);
      // Pop and push land on the same edge
      req_pop_o   <= (state_q == cu_cache_pkg::seq_pop_trans);
      rsp_push_o  <= (state_q == cu_cache_pkg::seq_pop_trans);
    end
  end

  // --------------------
  // Command payload
  // --------------------
  // Head stays put until the pop, so tracking it every cycle is safe
  always_ff @(posedge ap_clk) begin
    mem_addr_o  <= head_addr;
    mem_wdata_o <= head_wdata;
    mem_wstrb_o <= (head_cmd == cu_cache_pkg::CMD_WRITE) ? head_wstrb : '0;
    cmd_q       <= head_cmd;
    tag_q       <= head_tag;
  end

  // Read data capture
  always_ff @(posedge ap_clk) begin
    if (mem_rvalid_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  // Writes return zero data
  assign rsp_rdata = (cmd_q == cu_cache_pkg::CMD_WRITE) ? '0 : rdata_q;
  assign rsp_din_o = {cmd_q, tag_q, rsp_rdata};

  assign busy_o = (state_q != cu_cache_pkg::seq_ready);

endmodule

`default_nettype wire

/* hw/cu_cache.sv */
/*
  Command front end of the cache port, memory port is the outer boundary
  req_valid_i is a one-cycle strobe, hold off while req_prog_full_o is high
  A strobe into a full request FIFO is lost
  Responses leave in request order, two cycles after their pop
  done_o lags the idle condition by two registers
*/
`timescale 1ns/1ps
`default_nettype none

module cu_cache (
  input  logic                ap_clk,
  input  logic                areset_control,
  input  logic                req_valid_i,
  input  cu_cache_pkg::cmd_t  req_cmd_i,
  input  cu_cache_pkg::addr_t req_addr_i,
  input  cu_cache_pkg::data_t req_wdata_i,
  input  cu_cache_pkg::strb_t req_wstrb_i,
  input  cu_cache_pkg::tag_t  req_tag_i,
  input  logic                mem_ready_i,
  input  logic                mem_rvalid_i,
  input  cu_cache_pkg::data_t mem_rdata_i,
  input  logic                rsp_ready_i,
  output logic                req_prog_full_o,
  output logic                mem_valid_o,
  output cu_cache_pkg::addr_t mem_addr_o,
  output cu_cache_pkg::data_t mem_wdata_o,
  output cu_cache_pkg::strb_t mem_wstrb_o,
  output logic                rsp_valid_o,
  output cu_cache_pkg::cmd_t  rsp_cmd_o,
  output cu_cache_pkg::tag_t  rsp_tag_o,
  output cu_cache_pkg::data_t rsp_rdata_o,
  output logic                done_o
);

  // Input register
  logic                              req_valid_q;
  logic [cu_cache_pkg::REQ_BITS-1:0] req_din_q;

  // Request FIFO
  logic [cu_cache_pkg::REQ_BITS-1:0] req_head;
  logic                              req_pop;
  logic                              req_empty;
  logic                              req_full;

  // Response FIFO
  logic [cu_cache_pkg::RSP_BITS-1:0] rsp_din;
  logic [cu_cache_pkg::RSP_BITS-1:0] rsp_head;
  logic                              rsp_push;
  logic                              rsp_pop;
  logic                              rsp_empty;
  logic                              rsp_prog_full;

  // Output stage
  logic                              rsp_ready_q;
  logic                              rsp_valid_s1;
  logic [cu_cache_pkg::RSP_BITS-1:0] rsp_s1;

  logic seq_busy;
  logic idle;
  logic done_s1;

  // --------------------
  // Input register
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge ap_clk) begin
    req_din_q <= {req_cmd_i, req_addr_i, req_wdata_i, req_wstrb_i, req_tag_i};
  end

  // Request queue, push one cycle after the strobe
  sync_fifo #(
    .WIDTH       (cu_cache_pkg::REQ_BITS),
    .DEPTH       (cu_cache_pkg::FIFO_DEPTH),
    .PROG_THRESH (cu_cache_pkg::FIFO_PROG_THRESH)
  ) req_fifo_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .wr_en_i        (req_valid_q),
    .din_i          (req_din_q),
    .rd_en_i        (req_pop),
    .dout_o         (req_head),
    .empty_o        (req_empty),
    .full_o         (req_full),
    .prog_full_o    (req_prog_full_o)
  );

  cache_cmd_sequencer seq_i (
    .ap_clk          (ap_clk),
    .areset_control  (areset_control),
    .req_empty_i     (req_empty),
    .req_head_i      (req_head),
    .rsp_prog_full_i (rsp_prog_full),
    .mem_ready_i     (mem_ready_i),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i),
    .req_pop_o       (req_pop),
    .rsp_push_o      (rsp_push),
    .rsp_din_o       (rsp_din),
    .mem_valid_o     (mem_valid_o),
    .mem_addr_o      (mem_addr_o),
    .mem_wdata_o     (mem_wdata_o),
    .mem_wstrb_o     (mem_wstrb_o),
    .busy_o          (seq_busy)
  );

  // Response queue, never fills since the sequencer stops at prog_full
  sync_fifo #(
    .WIDTH       (cu_cache_pkg::RSP_BITS),
    .DEPTH       (cu_cache_pkg::FIFO_DEPTH),
    .PROG_THRESH (cu_cache_pkg::FIFO_PROG_THRESH)
  ) rsp_fifo_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .wr_en_i        (rsp_push),
    .din_i          (rsp_din),
    .rd_en_i        (rsp_pop),
    .dout_o         (rsp_head),
    .empty_o        (rsp_empty),
    .full_o         (),
    .prog_full_o    (rsp_prog_full)
  );

  // --------------------
  // Output stage
  // --------------------
  // Pop on the registered ready
  assign rsp_pop = rsp_ready_q & ~rsp_empty;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      rsp_ready_q  <= 1'b0;
      rsp_valid_s1 <= 1'b0;
      rsp_valid_o  <= 1'b0;
    end else begin
      rsp_ready_q  <= rsp_ready_i;
      rsp_valid_s1 <= rsp_pop;
      rsp_valid_o  <= rsp_valid_s1;
    end
  end

  // Payload follows the valid pipeline
  always_ff @(posedge ap_clk) begin
    rsp_s1                              <= rsp_head;
    {rsp_cmd_o, rsp_tag_o, rsp_rdata_o} <= rsp_s1;
  end

  // --------------------
  // Done
  // --------------------
  assign idle = req_empty & rsp_empty & ~seq_busy & mem_ready_i;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      done_s1 <= 1'b0;
      done_o  <= 1'b0;
    end else begin
      done_s1 <= idle;
      done_o  <= done_s1;
    end
  end

endmodule

`default_nettype wire

/* tests/cu_cache_assert.sv */
/*
  Protocol checker bound into cu_cache
  Read commands carry no byte strobes on the memory port
  Commands only go out while the memory is ready
  A registered request strobe must never meet a full request FIFO
*/
`timescale 1ns/1ps
`default_nettype none

module cu_cache_assert (
  input logic                ap_clk,
  input logic                areset_control,
  input logic                mem_valid_i,
  input logic                mem_ready_i,
  input cu_cache_pkg::strb_t mem_wstrb_i,
  input logic                issue_read_i,
  input logic                req_push_i,
  input logic                req_full_i
);

  // Strobes masked on reads, read known from the FSM state
  a_read_no_strobe: assert property (
    @(posedge ap_clk) disable iff (areset_control)
    (mem_valid_i && issue_read_i) |-> (mem_wstrb_i == '0)
  ) else $error("read command issued with nonzero mem_wstrb_o");

  // No command while the memory is busy
  a_valid_needs_ready: assert property (
    @(posedge ap_clk) disable iff (areset_control)
    mem_valid_i |-> mem_ready_i
  ) else $error("mem_valid_o asserted while mem_ready_i is low");

  // Registered strobe into a full FIFO would be dropped
  a_no_lost_request: assert property (
    @(posedge ap_clk) disable iff (areset_control)
    req_push_i |-> !req_full_i
  ) else $error("request strobe arrived while the request FIFO was full");

endmodule

bind cu_cache cu_cache_assert cu_cache_assert_i (
  .ap_clk         (ap_clk),
  .areset_control (areset_control),
  .mem_valid_i    (mem_valid_o),
  .mem_ready_i    (mem_ready_i),
  .mem_wstrb_i    (mem_wstrb_o),
  .issue_read_i   (seq_i.state_q == cu_cache_pkg::seq_read),
  .req_push_i     (req_valid_q),
  .req_full_i     (req_full)
);

`default_nettype wire

/* tests/cu_cache_tb.sv */
/*
  Testbench for cu_cache, random stimulus from an LCG with a fixed seed
  Memory model answers reads after 1 to 4 cycles
  It only drops mem_ready_i in the gap after a command strobe
  Addresses are word aligned and fold into a 64-word model, bits [7:2]
  Reference model predicts every response in request order
  Run ends at a cycle limit scaled from the request count
*/
`timescale 1ns/1ps
`default_nettype none

module cu_cache_tb;

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 4;
  localparam int MEM_WORDS      = 64;
  localparam int N_WR_RD        = 16;
  localparam int N_MIXED        = 40;
  localparam int N_RD_MASK      = 8;
  localparam int N_BURST_MAX    = 48;
  // Cycles req_prog_full_o must hold, longer than any single command
  localparam int FULL_HOLD      = 32;
  localparam int MAX_REQS       = 2 * N_WR_RD + N_MIXED + N_RD_MASK + N_BURST_MAX + 1;
  // Sequencer, read delay, ready gap and output pipe
  localparam int CYCLES_PER_REQ = 24;
  localparam int TIMEOUT_CYCLES = MAX_REQS * CYCLES_PER_REQ + 200;
  localparam logic [31:0] SEED  = 32'ha45073fc;

  logic                ap_clk = 1'b0;
  logic                areset_control;
  logic                req_valid_i;
  cu_cache_pkg::cmd_t  req_cmd_i;
  cu_cache_pkg::addr_t req_addr_i;
  cu_cache_pkg::data_t req_wdata_i;
  cu_cache_pkg::strb_t req_wstrb_i;
  cu_cache_pkg::tag_t  req_tag_i;
  logic                mem_ready_i;
  logic                mem_rvalid_i;
  cu_cache_pkg::data_t mem_rdata_i;
  logic                rsp_ready_i;
  logic                req_prog_full_o;
  logic                mem_valid_o;
  cu_cache_pkg::addr_t mem_addr_o;
  cu_cache_pkg::data_t mem_wdata_o;
  cu_cache_pkg::strb_t mem_wstrb_o;
  logic                rsp_valid_o;
  cu_cache_pkg::cmd_t  rsp_cmd_o;
  cu_cache_pkg::tag_t  rsp_tag_o;
  cu_cache_pkg::data_t rsp_rdata_o;
  logic                done_o;

  // Expected responses, request order
  cu_cache_pkg::cmd_t  exp_cmd_q[$];
  cu_cache_pkg::tag_t  exp_tag_q[$];
  cu_cache_pkg::data_t exp_data_q[$];
  // Expected memory commands
  cu_cache_pkg::cmd_t  iss_cmd_q[$];
  cu_cache_pkg::addr_t iss_addr_q[$];
  cu_cache_pkg::data_t iss_wdata_q[$];
  cu_cache_pkg::strb_t iss_strb_q[$];

  cu_cache_pkg::data_t ref_mem   [MEM_WORDS];
  cu_cache_pkg::data_t mem_model [MEM_WORDS];
  cu_cache_pkg::addr_t wr_addr   [N_WR_RD];

  logic [31:0]        stim_state;
  logic [31:0]        mem_state;
  cu_cache_pkg::tag_t next_tag;
  string              test_name;
  int                 errors;
  int                 checks;
  int                 tests_run;
  int                 rsp_count;
  int                 errors_at_start;
  int                 rsp_at_start;
  int                 cycle_count = 0;

  cu_cache cu_cache_i (.*);

  always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

  always @(posedge ap_clk) cycle_count <= cycle_count + 1;

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] stim_rand();
    stim_state = lcg_step(stim_state);
    return stim_state;
  endfunction

  function automatic logic [31:0] mem_rand();
    mem_state = lcg_step(mem_state);
    return mem_state;
  endfunction

  // Initial memory contents, every index bit shows up
  function automatic cu_cache_pkg::data_t fill_word(input int idx);
    return {16'hc0de ^ 16'(idx * 16'h0101), 16'(idx << 2)};
  endfunction

  // Byte lane merge under strobes
  function automatic cu_cache_pkg::data_t merge_bytes(input cu_cache_pkg::data_t old_w,
                                                      input cu_cache_pkg::data_t new_w,
                                                      input cu_cache_pkg::strb_t strb);
    cu_cache_pkg::data_t res;
    res = old_w;
    for (int b = 0; b < cu_cache_pkg::STRB_W; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_data(input string field, input cu_cache_pkg::data_t exp_v,
                            input cu_cache_pkg::data_t act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("mismatch %s %s expected %h actual %h", test_name, field, exp_v, act_v);
    end
  endtask

  task automatic check_tag(input string field, input cu_cache_pkg::tag_t exp_v,
                           input cu_cache_pkg::tag_t act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("mismatch %s %s expected %h actual %h", test_name, field, exp_v, act_v);
    end
  endtask

  task automatic check_cmd(input string field, input cu_cache_pkg::cmd_t exp_v,
                           input cu_cache_pkg::cmd_t act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("mismatch %s %s expected %h actual %h", test_name, field, exp_v, act_v);
    end
  endtask

  task automatic check_addr(input string field, input cu_cache_pkg::addr_t exp_v,
                            input cu_cache_pkg::addr_t act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("mismatch %s %s expected %h actual %h", test_name, field, exp_v, act_v);
    end
  endtask

  task automatic check_strb(input string field, input cu_cache_pkg::strb_t exp_v,
                            input cu_cache_pkg::strb_t act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("mismatch %s %s expected %h actual %h", test_name, field, exp_v, act_v);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("error in %s: %s", test_name, what);
  endtask

  // --------------------
  // Memory model
  // --------------------
  int          rd_wait;
  int          rd_index;
  int          ready_low;
  logic        ready_hold;
  logic [31:0] mr;

  initial begin
    mem_ready_i  = 1'b1;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    mem_state    = ~SEED;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_model[i] = fill_word(i);
    end
  end

  always @(negedge ap_clk) begin
    if (areset_control) begin
      mem_ready_i  = 1'b1;
      mem_rvalid_i = 1'b0;
      rd_wait      = 0;
      ready_low    = 0;
      ready_hold   = 1'b0;
    end else begin
      mem_rvalid_i = 1'b0;
      // Read data pulse
      if (rd_wait != 0) begin
        rd_wait = rd_wait - 1;
        if (rd_wait == 0) begin
          mem_rvalid_i = 1'b1;
          mem_rdata_i  = mem_model[rd_index];
        end
      end
      if (ready_low != 0) begin
        ready_low = ready_low - 1;
        if (ready_low == 0) begin
          mem_ready_i = 1'b1;
        end
      end
      // Ready stays up one cycle past the strobe, then may drop
      if (ready_hold) begin
        ready_hold = 1'b0;
        mr         = mem_rand();
        ready_low  = mr[17:16];
        if (ready_low != 0) begin
          mem_ready_i = 1'b0;
        end
      end
      if (mem_valid_o) begin
        ready_hold = 1'b1;
        if (iss_cmd_q.size() == 0) begin
          report_error("memory command issued with no request outstanding");
        end else begin
          check_addr("mem_addr", iss_addr_q.pop_front(), mem_addr_o);
          check_strb("mem_wstrb", iss_strb_q.pop_front(), mem_wstrb_o);
          if (iss_cmd_q.pop_front() == cu_cache_pkg::CMD_WRITE) begin
            check_data("mem_wdata", iss_wdata_q.pop_front(), mem_wdata_o);
            mem_model[mem_addr_o[7:2]] = merge_bytes(mem_model[mem_addr_o[7:2]],
                                                     mem_wdata_o, mem_wstrb_o);
          end else begin
            void'(iss_wdata_q.pop_front());
            mr       = mem_rand();
            rd_wait  = 1 + mr[21:20];
            rd_index = mem_addr_o[7:2];
          end
        end
      end
    end
  end

  // --------------------
  // Response monitor
  // --------------------
  always @(negedge ap_clk) begin
    if (!areset_control && rsp_valid_o) begin
      if (exp_cmd_q.size() == 0) begin
        report_error("response arrived with no request outstanding");
      end else begin
        check_cmd("rsp_cmd", exp_cmd_q.pop_front(), rsp_cmd_o);
        check_tag("rsp_tag", exp_tag_q.pop_front(), rsp_tag_o);
        check_data("rsp_rdata", exp_data_q.pop_front(), rsp_rdata_o);
        rsp_count++;
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  // Called on a falling edge, updates the reference model too
  task automatic drive_req(input cu_cache_pkg::cmd_t cmd, input cu_cache_pkg::addr_t addr,
                           input cu_cache_pkg::data_t wdata, input cu_cache_pkg::strb_t wstrb);
    int idx;
    idx         = addr[7:2];
    req_valid_i = 1'b1;
    req_cmd_i   = cmd;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_wstrb_i = wstrb;
    req_tag_i   = next_tag;
    exp_cmd_q.push_back(cmd);
    exp_tag_q.push_back(next_tag);
    iss_cmd_q.push_back(cmd);
    iss_addr_q.push_back(addr);
    iss_wdata_q.push_back(wdata);
    if (cmd == cu_cache_pkg::CMD_WRITE) begin
      ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, wstrb);
      exp_data_q.push_back('0);
      iss_strb_q.push_back(wstrb);
    end else begin
      exp_data_q.push_back(ref_mem[idx]);
      iss_strb_q.push_back('0);
    end
    next_tag = next_tag + 1'b1;
  endtask

  // Holds off while the request FIFO is near full
  task automatic send_req(input cu_cache_pkg::cmd_t cmd, input cu_cache_pkg::addr_t addr,
                          input cu_cache_pkg::data_t wdata, input cu_cache_pkg::strb_t wstrb);
    @(negedge ap_clk);
    while (req_prog_full_o) begin
      req_valid_i = 1'b0;
      @(negedge ap_clk);
    end
    drive_req(cmd, addr, wdata, wstrb);
  endtask

  task automatic drive_random();
    logic [31:0] r;
    r = stim_rand();
    drive_req(cu_cache_pkg::cmd_t'(r[30]), cu_cache_pkg::addr_t'({r[29:24], 2'b00}),
              stim_rand(), r[19:16]);
  endtask

  task automatic end_stream();
    @(negedge ap_clk);
    req_valid_i = 1'b0;
  endtask

  // All responses in, then done_o back up
  task automatic wait_idle();
    int guard;
    while (exp_cmd_q.size() != 0) @(negedge ap_clk);
    guard = 0;
    while (!done_o && guard < 16) begin
      @(negedge ap_clk);
      guard++;
    end
    if (!done_o) begin
      report_error("done_o did not return high after the last response");
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
    rsp_at_start    = rsp_count;
  endtask

  task automatic finish_test();
    tests_run++;
    $display("test %s finished: %0d responses, %0d errors", test_name,
             rsp_count - rsp_at_start, errors - errors_at_start);
  endtask

  // --------------------
  // Test sequence
  // --------------------
  logic [31:0] r;
  int          burst;
  int          full_run;
  logic        seen_low;
  logic        got_rsp;

  initial begin
    areset_control = 1'b1;
    req_valid_i    = 1'b0;
    req_cmd_i      = cu_cache_pkg::CMD_READ;
    req_addr_i     = '0;
    req_wdata_i    = '0;
    req_wstrb_i    = '0;
    req_tag_i      = '0;
    rsp_ready_i    = 1'b1;
    stim_state     = SEED;
    next_tag       = '0;
    errors         = 0;
    checks         = 0;
    tests_run      = 0;
    rsp_count      = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = fill_word(i);
    end
    repeat (RESET_CYCLES) @(negedge ap_clk);
    areset_control = 1'b0;

    start_test("reset_done");
    repeat (4) @(negedge ap_clk);
    checks++;
    if (!done_o) begin
      report_error("done_o not high after reset");
    end
    finish_test();

    // Strobed writes, then reads of the same words
    start_test("write_read");
    for (int i = 0; i < N_WR_RD; i++) begin
      r          = stim_rand();
      wr_addr[i] = cu_cache_pkg::addr_t'({r[29:24], 2'b00});
      send_req(cu_cache_pkg::CMD_WRITE, wr_addr[i], stim_rand(), r[19:16]);
    end
    for (int i = 0; i < N_WR_RD; i++) begin
      r = stim_rand();
      send_req(cu_cache_pkg::CMD_READ, wr_addr[i], stim_rand(), r[19:16]);
    end
    end_stream();
    wait_idle();
    finish_test();

    // Mixed stream with a wobbling consumer
    start_test("mixed_order");
    for (int i = 0; i < N_MIXED; i++) begin
      @(negedge ap_clk);
      while (req_prog_full_o) begin
        req_valid_i = 1'b0;
        @(negedge ap_clk);
      end
      drive_random();
      r           = stim_rand();
      rsp_ready_i = (r[25:24] != 2'b00);
    end
    end_stream();
    rsp_ready_i = 1'b1;
    wait_idle();
    finish_test();

    // Reads carrying strobes, the port must show none
    start_test("read_strobe");
    for (int i = 0; i < N_RD_MASK; i++) begin
      r = stim_rand();
      send_req(cu_cache_pkg::CMD_READ, cu_cache_pkg::addr_t'({r[29:24], 2'b00}),
               stim_rand(), 4'hf);
    end
    end_stream();
    wait_idle();
    finish_test();

    // Consumer stalled until the request FIFO backs up
    start_test("backpressure");
    @(negedge ap_clk);
    rsp_ready_i = 1'b0;
    burst       = 0;
    full_run    = 0;
    // Refill whenever prog_full drops, a stalled sequencer lets it hold
    while (full_run < FULL_HOLD && burst < N_BURST_MAX) begin
      @(negedge ap_clk);
      if (req_prog_full_o) begin
        full_run++;
        req_valid_i = 1'b0;
      end else begin
        full_run = 0;
        drive_random();
        burst++;
      end
    end
    end_stream();
    checks++;
    if (full_run < FULL_HOLD) begin
      report_error("req_prog_full_o did not stay high with responses stalled");
    end
    if (rsp_count != rsp_at_start) begin
      report_error("responses were delivered while rsp_ready_i was low");
    end
    rsp_ready_i = 1'b1;
    wait_idle();
    checks++;
    if (rsp_count - rsp_at_start != burst) begin
      report_error("response count after release differs from the burst length");
    end
    finish_test();

    // done_o drops with work in flight, returns after the response
    start_test("done_level");
    r = stim_rand();
    send_req(cu_cache_pkg::CMD_READ, cu_cache_pkg::addr_t'({r[29:24], 2'b00}),
             stim_rand(), r[19:16]);
    end_stream();
    seen_low = 1'b0;
    got_rsp  = 1'b0;
    while (!got_rsp) begin
      @(negedge ap_clk);
      if (rsp_valid_o) begin
        got_rsp = 1'b1;
      end else if (!done_o) begin
        seen_low = 1'b1;
      end else if (seen_low) begin
        report_error("done_o rose while a response was outstanding");
      end
    end
    checks++;
    if (!seen_low) begin
      report_error("done_o stayed high with a request outstanding");
    end
    wait_idle();
    finish_test();

    $display("summary: %0d tests, %0d responses, %0d checks, %0d errors",
             tests_run, rsp_count, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Hang guard
  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("timeout: run stopped after %0d cycles in test %s", cycle_count, test_name);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
hw/cu_cache_pkg.sv
hw/sync_fifo.sv
hw/cache_cmd_sequencer.sv
hw/cu_cache.sv
tests/cu_cache_assert.sv
tests/cu_cache_tb.sv
